// File: sources.f
source/rvIsaPkg.sv
source/rvCtrlPkg.sv
source/instLatch.sv
source/instDecode.sv
source/regFile.sv
source/rvAlu.sv
source/writebackStage.sv
source/rvExecCore.sv
verif/tbClockGen.sv
verif/tbRvExecCore.sv

// File: verif/tbRvExecCore.sv
module tbRvExecCore
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
();

    logic                  clk;
    logic                  arstN;
    logic                  instValid;
    Inst                   inst;
    logic [XLEN-1:0]       pc;
    logic                  wbValid;
    logic [REG_ADDR_W-1:0] wbRd;
    logic [XLEN-1:0]       wbData;
    logic                  redirectValid;
    logic [XLEN-1:0]       redirectPc;
    logic                  illegalInst;

    ExecResult   expIn;       // expectation travelling with the strobe
    ExecResult   expD1;
    ExecResult   expD2;       // lines up with the output pulse
    logic [31:0] shadow [32];
    logic [31:0] lcgState = 32'd3;
    logic [31:0] pcNext   = 32'h0000_1000;
    int          errCount = 0;

    tbClockGen u_clk (
        .clk   (clk),
        .arstN (arstN)
    );

    rvExecCore u_dut (
        .clk           (clk),
        .arstN         (arstN),
        .instValid     (instValid),
        .inst          (inst),
        .pc            (pc),
        .wbValid       (wbValid),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .illegalInst   (illegalInst)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expD1 <= '0;
            expD2 <= '0;
        end else begin
            expD1 <= instValid ? expIn : '0;
            expD2 <= expD1;
        end
    end

    // **************************************************
    // helpers
    // **************************************************
    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [4:0] randReg();
        logic [31:0] r;
        r = lcgNext();
        return (r[27:23] == 5'd0) ? 5'd1 : r[27:23];    // never x0
    endfunction

    function automatic Inst encR(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic Inst encI(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd,
                                 input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic Inst encB(input logic [12:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BR_OP};
    endfunction

    function automatic Inst encU(input logic [19:0] imm, input logic [4:0] rd,
                                 input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic Inst encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL_OP};
    endfunction

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic refTaken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // expected outputs of one instruction, straight from the RV32I encodings
    function automatic ExecResult predict(input Inst i, input logic [31:0] pcv);
        ExecResult   e;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [2:0]  f3;
        logic [6:0]  f7;
        w    = i;
        f3   = w[14:12];
        f7   = w[31:25];
        a    = shadow[w[19:15]];
        b    = shadow[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        e    = '0;
        e.rd = w[11:7];
        case (w[6:0])
            ALUR_OP: begin
                e.valid   = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                e.data    = refAlu(f3, f7[5], a, b);
                e.illegal = !e.valid;
            end
            ALUI_OP: begin
                if (f3 == 3'b001)
                    e.valid = f7 == 7'h00;
                else if (f3 == 3'b101)
                    e.valid = f7 == 7'h00 || f7 == 7'h20;
                else
                    e.valid = 1'b1;
                e.data    = refAlu(f3, f3 == 3'b101 && f7[5], a, immI);
                e.illegal = !e.valid;
            end
            LUI_OP: begin
                e.valid = 1'b1;
                e.data  = {w[31:12], 12'b0};
            end
            AUIPC_OP: begin
                e.valid = 1'b1;
                e.data  = pcv + {w[31:12], 12'b0};
            end
            JAL_OP: begin
                e.valid      = 1'b1;
                e.data       = pcv + 32'd4;
                e.redirect   = 1'b1;
                e.redirectPc = pcv + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            JALR_OP: begin
                e.valid      = f3 == 3'b000;
                e.data       = pcv + 32'd4;
                e.redirect   = e.valid;
                e.redirectPc = (a + immI) & 32'hFFFF_FFFE;
                e.illegal    = !e.valid;
            end
            BR_OP: begin
                e.illegal    = f3 == 3'b010 || f3 == 3'b011;
                e.redirect   = !e.illegal && refTaken(f3, a, b);
                e.redirectPc = pcv + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    task automatic issue(input Inst i);
        ExecResult e;
        e = predict(i, pcNext);
        if (e.valid && e.rd != 5'd0)
            shadow[e.rd] = e.data;
        @(posedge clk);
        instValid <= 1'b1;
        inst      <= i;
        pc        <= pcNext;
        expIn     <= e;
        pcNext = pcNext + 32'd4;
    endtask

    task automatic idle();
        @(posedge clk);
        instValid <= 1'b0;
        expIn     <= '0;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errCount++;
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Errors found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic reportTimeout(input string what);
        errCount++;
        $display("timeout while waiting for %s", what);
        $display("Errors found");
        $fatal(1, "stopped on timeout");
    endtask

    // **************************************************
    // checks, every cycle against the delayed expectation
    // **************************************************
    wbValidChk: assert property (@(posedge clk) disable iff (!arstN)
        wbValid == expD2.valid)
        else reportMismatch("wbValid", $sampled(wbValid), $sampled(expD2.valid));

    wbRdChk: assert property (@(posedge clk) disable iff (!arstN)
        expD2.valid |-> wbRd == expD2.rd)
        else reportMismatch("wbRd", $sampled(wbRd), $sampled(expD2.rd));

    wbDataChk: assert property (@(posedge clk) disable iff (!arstN)
        expD2.valid |-> wbData == expD2.data)
        else reportMismatch("wbData", $sampled(wbData), $sampled(expD2.data));

    redirectValidChk: assert property (@(posedge clk) disable iff (!arstN)
        redirectValid == expD2.redirect)
        else reportMismatch("redirectValid", $sampled(redirectValid),
                            $sampled(expD2.redirect));

    redirectPcChk: assert property (@(posedge clk) disable iff (!arstN)
        expD2.redirect |-> redirectPc == expD2.redirectPc)
        else reportMismatch("redirectPc", $sampled(redirectPc), $sampled(expD2.redirectPc));

    illegalChk: assert property (@(posedge clk) disable iff (!arstN)
        illegalInst == expD2.illegal)
        else reportMismatch("illegalInst", $sampled(illegalInst), $sampled(expD2.illegal));

    // **************************************************
    // stimulus
    // **************************************************
    initial begin
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  prevRd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          n;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        expIn     = '0;
        for (int k = 0; k < 32; k++)
            shadow[k] = '0;

        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!arstN && n < 10);
        if (!arstN)
            reportTimeout("reset release");

        repeat (4) idle();    // outputs must stay quiet

        // random register contents, lui followed by a dependent addi
        for (int k = 1; k < 32; k++) begin
            r = lcgNext();
            if (k < 16) begin
                issue(encI(r[11:0], 5'd0, ADD_F3, k[4:0], ALUI_OP));
            end else begin
                issue(encU(r[31:12], k[4:0], LUI_OP));
                issue(encI(r[11:0], k[4:0], ADD_F3, k[4:0], ALUI_OP));
            end
        end

        for (int op = 0; op < 10; op++) begin
            for (int rep = 0; rep < 4; rep++) begin
                r  = lcgNext();
                f3 = (op < 8) ? op[2:0] : ((op == 8) ? ADD_F3 : SR_F3);
                f7 = (op < 8) ? BASE_F7 : ALT_F7;
                issue(encR(f7, r[24:20], r[19:15], f3, randReg(), ALUR_OP));
            end
        end

        for (int op = 0; op < 9; op++) begin
            for (int rep = 0; rep < 4; rep++) begin
                r  = lcgNext();
                f3 = (op < 8) ? op[2:0] : SR_F3;
                f7 = (op == 8) ? ALT_F7 : BASE_F7;
                if (f3 == SLL_F3 || f3 == SR_F3)
                    issue(encI({f7, r[24:20]}, r[19:15], f3, randReg(), ALUI_OP));
                else
                    issue(encI(r[31:20], r[19:15], f3, randReg(), ALUI_OP));
            end
        end

        // sign and shift-amount corners
        issue(encI({ALT_F7, 5'd31}, 5'd31, SR_F3, 5'd6, ALUI_OP));
        issue(encI({BASE_F7, 5'd0}, 5'd31, SLL_F3, 5'd7, ALUI_OP));
        issue(encI(12'hFFF, 5'd0, SLTU_F3, 5'd8, ALUI_OP));
        issue(encI(12'h800, 5'd31, SLT_F3, 5'd9, ALUI_OP));
        issue(encI(12'h123, 5'd1, ADD_F3, 5'd0, ALUI_OP));          // write to x0
        issue(encR(BASE_F7, 5'd0, 5'd0, ADD_F3, 5'd9, ALUR_OP));
        idle();

        // chain where every instruction consumes the previous rd
        prevRd = 5'd1;
        for (int k = 0; k < 12; k++) begin
            r  = lcgNext();
            rd = randReg();
            if (k[0])
                issue(encR(k[1] ? ALT_F7 : BASE_F7, r[24:20], prevRd, ADD_F3, rd, ALUR_OP));
            else
                issue(encI(r[11:0], prevRd, XOR_F3, rd, ALUI_OP));
            prevRd = rd;
        end
        idle();

        // pc relative results and jumps
        r = lcgNext();
        issue(encU(r[31:12], 5'd12, AUIPC_OP));
        issue(encJ({r[20:1], 1'b0}, 5'd13));
        issue(encR(BASE_F7, 5'd12, 5'd13, ADD_F3, 5'd14, ALUR_OP));
        issue(encJ(21'h1FFFF8, 5'd0));
        issue(encI({r[11:1], 1'b1}, 5'd14, JALR_F3, 5'd15, JALR_OP));    // odd target
        issue(encI(12'h003, 5'd15, JALR_F3, 5'd15, JALR_OP));
        issue(encI(12'h000, 5'd1, 3'b001, 5'd16, JALR_OP));
        idle();

        // branches, x10 negative and x11 positive split signed from unsigned
        issue(encI(12'hFF0, 5'd0, ADD_F3, 5'd10, ALUI_OP));
        issue(encI(12'h005, 5'd0, ADD_F3, 5'd11, ALUI_OP));
        for (int k = 0; k < 8; k++) begin
            r = lcgNext();
            issue(encB({r[12:1], 1'b0}, 5'd11, 5'd10, k[2:0]));
            issue(encB({r[24:13], 1'b0}, 5'd10, 5'd11, k[2:0]));
            issue(encB(13'h010, 5'd11, 5'd11, k[2:0]));
            issue(encB(13'h1FF8, r[9:5], r[4:0], k[2:0]));
        end
        idle();

        // load, store, csr, ecall and mul, then read back what they name
        issue(encI(12'h000, 5'd1, 3'b010, 5'd3, 7'b0000011));
        issue(encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd8, 7'b0100011));
        issue(encI(12'h300, 5'd1, 3'b001, 5'd4, 7'b1110011));
        issue(Inst'(32'h0000_0073));
        issue(encR(7'h01, 5'd2, 5'd1, ADD_F3, 5'd5, ALUR_OP));
        issue(encR(BASE_F7, 5'd0, 5'd3, ADD_F3, 5'd20, ALUR_OP));
        issue(encR(BASE_F7, 5'd0, 5'd4, ADD_F3, 5'd21, ALUR_OP));
        issue(encR(BASE_F7, 5'd0, 5'd5, ADD_F3, 5'd22, ALUR_OP));
        idle();

        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((expD1 != '0 || expD2 != '0) && n < 8);
        if (expD1 != '0 || expD2 != '0)
            reportTimeout("the last results to drain");

        repeat (2) @(posedge clk);
        if (errCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: verif/tbClockGen.sv
module tbClockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // period 4
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

// File: source/rvExecCore.sv
module rvExecCore
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instValid,
    input  Inst                   inst,
    input  logic [XLEN-1:0]       pc,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData,
    output logic                  redirectValid,
    output logic [XLEN-1:0]       redirectPc,
    output logic                  illegalInst
);

    FetchPkt         fetchPkt;
    Ctrl             ctrl;
    ExecResult       nextResult;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;

    instLatch u_latch (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .fetchPkt  (fetchPkt)
    );

    instDecode u_decode (
        .fetchPkt (fetchPkt),
        .ctrl     (ctrl)
    );

    // write port fed straight from the ALU result
    regFile u_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (fetchPkt.inst.rType.rs1),
        .rs2Addr (fetchPkt.inst.rType.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wen     (nextResult.valid),
        .wAddr   (nextResult.rd),
        .wData   (nextResult.data)
    );

    rvAlu u_alu (
        .fetchPkt   (fetchPkt),
        .ctrl       (ctrl),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .nextResult (nextResult)
    );

    writebackStage u_wb (
        .clk           (clk),
        .arstN         (arstN),
        .nextResult    (nextResult),
        .wbValid       (wbValid),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .illegalInst   (illegalInst)
    );

endmodule

// File: source/writebackStage.sv
module writebackStage
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  ExecResult             nextResult,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData,
    output logic                  redirectValid,
    output logic [XLEN-1:0]       redirectPc,
    output logic                  illegalInst
);

    ExecResult resQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resQ <= '0;
        end else begin
            // pulses last one cycle, payload holds until the next one
            resQ.valid    <= nextResult.valid;
            resQ.redirect <= nextResult.redirect;
            resQ.illegal  <= nextResult.illegal;
            if (nextResult.valid) begin
                resQ.rd   <= nextResult.rd;
                resQ.data <= nextResult.data;
            end
            if (nextResult.redirect) begin
                resQ.redirectPc <= nextResult.redirectPc;
            end
        end
    end

    assign wbValid       = resQ.valid;
    assign wbRd          = resQ.rd;
    assign wbData        = resQ.data;
    assign redirectValid = resQ.redirect;
    assign redirectPc    = resQ.redirectPc;
    assign illegalInst   = resQ.illegal;

    // an illegal encoding never decodes as a jump or a branch
    noRedirectOnIllegal: assert property (@(posedge clk) disable iff (!arstN)
        !(redirectValid && illegalInst));

endmodule

// File: source/rvAlu.sv
module rvAlu
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  FetchPkt         fetchPkt,
    input  Ctrl             ctrl,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    output ExecResult       nextResult
);

    Inst             inst;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic [XLEN-1:0] aluOut;
    logic            brTaken;

    assign inst = fetchPkt.inst;

    // **************************************************
    // immediates and operand select
    // **************************************************
    assign immI = {{20{inst.iType.imm11_0[11]}}, inst.iType.imm11_0};
    assign immU = {inst.uType.imm31_12, 12'b0};
    assign immJ = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19_12,
                   inst.jType.imm11, inst.jType.imm10_1, 1'b0};
    assign immB = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                   inst.bType.imm10_5, inst.bType.imm4_1, 1'b0};

    assign op1 = (ctrl.op1Sel == OP1_PC) ? fetchPkt.pc : rs1Data;

    always_comb begin
        case (ctrl.op2Sel)
            OP2_IMI : op2 = immI;
            OP2_IMU : op2 = immU;
            OP2_IMJ : op2 = immJ;
            default : op2 = rs2Data;
        endcase
    end

    assign shamt = op2[4:0];

    // **************************************************
    // ALU and branch compare
    // **************************************************
    always_comb begin
        case (ctrl.aluSel)
            ALU_ADD   : aluOut = op1 + op2;
            ALU_SUB   : aluOut = op1 - op2;
            ALU_AND   : aluOut = op1 & op2;
            ALU_OR    : aluOut = op1 | op2;
            ALU_XOR   : aluOut = op1 ^ op2;
            ALU_SLL   : aluOut = op1 << shamt;
            ALU_SRL   : aluOut = op1 >> shamt;
            ALU_SRA   : aluOut = $signed(op1) >>> shamt;
            ALU_SLT   : aluOut = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU  : aluOut = {31'b0, op1 < op2};
            ALU_JALR  : aluOut = (op1 + op2) & ~32'd1;    // target has bit 0 cleared
            ALU_COPY2 : aluOut = op2;
            default   : aluOut = '0;
        endcase
    end

    always_comb begin
        case (ctrl.brSel)
            BR_BEQ  : brTaken = rs1Data == rs2Data;
            BR_BNE  : brTaken = rs1Data != rs2Data;
            BR_BLT  : brTaken = $signed(rs1Data) < $signed(rs2Data);
            BR_BGE  : brTaken = $signed(rs1Data) >= $signed(rs2Data);
            BR_BLTU : brTaken = rs1Data < rs2Data;
            BR_BGEU : brTaken = rs1Data >= rs2Data;
            default : brTaken = 1'b0;
        endcase
    end

    assign nextResult.valid      = fetchPkt.valid && ctrl.rfWen;
    assign nextResult.rd         = inst.rType.rd;
    assign nextResult.data       = (ctrl.wbSel == WB_PC) ? fetchPkt.pc + 32'd4 : aluOut;
    assign nextResult.redirect   = fetchPkt.valid && (ctrl.jmpFlg || brTaken);
    // jal and jalr targets already come out of the ALU
    assign nextResult.redirectPc = (ctrl.brSel != BR_NONE) ? fetchPkt.pc + immB : aluOut;
    assign nextResult.illegal    = fetchPkt.valid && ctrl.illegal;

endmodule

// File: source/regFile.sv
module regFile
    import rvIsaPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [REG_ADDR_W-1:0] rs1Addr,
    input  logic [REG_ADDR_W-1:0] rs2Addr,
    output logic [XLEN-1:0]       rs1Data,
    output logic [XLEN-1:0]       rs2Data,
    input  logic                  wen,
    input  logic [REG_ADDR_W-1:0] wAddr,
    input  logic [XLEN-1:0]       wData
);

    // no storage behind x0
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // asynchronous reads, x0 hardwired to zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    // write data comes from the ALU of the instruction in the latch
    wDataKnown: assert property (@(posedge clk) disable iff (!arstN)
        wen |-> !$isunknown(wData));

endmodule

// File: source/instDecode.sv
module instDecode
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  FetchPkt fetchPkt,
    output Ctrl     ctrl
);

    logic [$bits(AluSel)+$bits(BrSel)+$bits(Op1Sel)+$bits(Op2Sel)+$bits(WbSel)-1:0] row;
    logic hit;
    logic rfWen;
    logic jmpFlg;
    Inst  inst;

    assign inst = fetchPkt.inst;

    // **************************************************
    // decode table over funct7, funct3 and opcode
    // **************************************************
    always_comb begin
        hit = 1'b1;
        casez ({inst.rType.funct7, inst.rType.funct3, inst.rType.opcode})
            // register-register
            {BASE_F7, ADD_F3 , ALUR_OP } : row = {ALU_ADD  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {ALT_F7 , ADD_F3 , ALUR_OP } : row = {ALU_SUB  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, SLL_F3 , ALUR_OP } : row = {ALU_SLL  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, SLT_F3 , ALUR_OP } : row = {ALU_SLT  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, SLTU_F3, ALUR_OP } : row = {ALU_SLTU , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, XOR_F3 , ALUR_OP } : row = {ALU_XOR  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, SR_F3  , ALUR_OP } : row = {ALU_SRL  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {ALT_F7 , SR_F3  , ALUR_OP } : row = {ALU_SRA  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, OR_F3  , ALUR_OP } : row = {ALU_OR   , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            {BASE_F7, AND_F3 , ALUR_OP } : row = {ALU_AND  , BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            // register-immediate, funct7 belongs to the immediate except on shifts
            {X_7    , ADD_F3 , ALUI_OP } : row = {ALU_ADD  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {BASE_F7, SLL_F3 , ALUI_OP } : row = {ALU_SLL  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {X_7    , SLT_F3 , ALUI_OP } : row = {ALU_SLT  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {X_7    , SLTU_F3, ALUI_OP } : row = {ALU_SLTU , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {X_7    , XOR_F3 , ALUI_OP } : row = {ALU_XOR  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {BASE_F7, SR_F3  , ALUI_OP } : row = {ALU_SRL  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {ALT_F7 , SR_F3  , ALUI_OP } : row = {ALU_SRA  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {X_7    , OR_F3  , ALUI_OP } : row = {ALU_OR   , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            {X_7    , AND_F3 , ALUI_OP } : row = {ALU_AND  , BR_NONE, OP1_RS1, OP2_IMI, WB_ALU};
            // conditional branches
            {X_7    , BEQ_F3 , BR_OP   } : row = {ALU_ADD  , BR_BEQ , OP1_RS1, OP2_RS2, WB_ALU};
            {X_7    , BNE_F3 , BR_OP   } : row = {ALU_ADD  , BR_BNE , OP1_RS1, OP2_RS2, WB_ALU};
            {X_7    , BLT_F3 , BR_OP   } : row = {ALU_ADD  , BR_BLT , OP1_RS1, OP2_RS2, WB_ALU};
            {X_7    , BGE_F3 , BR_OP   } : row = {ALU_ADD  , BR_BGE , OP1_RS1, OP2_RS2, WB_ALU};
            {X_7    , BLTU_F3, BR_OP   } : row = {ALU_ADD  , BR_BLTU, OP1_RS1, OP2_RS2, WB_ALU};
            {X_7    , BGEU_F3, BR_OP   } : row = {ALU_ADD  , BR_BGEU, OP1_RS1, OP2_RS2, WB_ALU};
            // jumps and upper immediates
            {X_7    , X_3    , JAL_OP  } : row = {ALU_ADD  , BR_NONE, OP1_PC , OP2_IMJ, WB_PC };
            {X_7    , JALR_F3, JALR_OP } : row = {ALU_JALR , BR_NONE, OP1_RS1, OP2_IMI, WB_PC };
            {X_7    , X_3    , LUI_OP  } : row = {ALU_COPY2, BR_NONE, OP1_RS1, OP2_IMU, WB_ALU};
            {X_7    , X_3    , AUIPC_OP} : row = {ALU_ADD  , BR_NONE, OP1_PC , OP2_IMU, WB_ALU};
            default : begin
                hit = 1'b0;
                row = {ALU_ADD, BR_NONE, OP1_RS1, OP2_RS2, WB_ALU};
            end
        endcase
    end

    assign rfWen  = hit && inst.rType.opcode != BR_OP;    // branches write nothing
    assign jmpFlg = hit && (inst.rType.opcode == JAL_OP || inst.rType.opcode == JALR_OP);

    assign ctrl = Ctrl'({row, rfWen, jmpFlg, !hit});

    // unknown bits in a wildcard field would still hit a row and decode clean
    instKnown: assert final (!fetchPkt.valid || !$isunknown(fetchPkt.inst));

endmodule

// File: source/instLatch.sv
module instLatch
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic            clk,
    input  logic            arstN,
    input  logic            instValid,
    input  Inst             inst,
    input  logic [XLEN-1:0] pc,
    output FetchPkt         fetchPkt
);

    logic            validQ;
    Inst             instQ;
    logic [XLEN-1:0] pcQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= instValid;    // one cycle per strobe
        end
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            instQ <= inst;
            pcQ   <= pc;
        end
    end

    assign fetchPkt = '{valid: validQ, inst: instQ, pc: pcQ};

    // fetch side must hand over word aligned addresses
    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        instValid |-> pc[1:0] == 2'b00);

endmodule

// File: source/rvCtrlPkg.sv
package rvCtrlPkg;
    import rvIsaPkg::*;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JALR, ALU_COPY2
    } AluSel;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } BrSel;

    typedef enum logic {OP1_RS1, OP1_PC} Op1Sel;
    typedef enum logic [1:0] {OP2_RS2, OP2_IMI, OP2_IMU, OP2_IMJ} Op2Sel;
    typedef enum logic {WB_ALU, WB_PC} WbSel;

    typedef struct packed {
        AluSel aluSel;
        BrSel  brSel;
        Op1Sel op1Sel;
        Op2Sel op2Sel;
        WbSel  wbSel;
        logic  rfWen;
        logic  jmpFlg;    // jal or jalr
        logic  illegal;
    } Ctrl;

    typedef struct packed {
        logic            valid;
        Inst             inst;
        logic [XLEN-1:0] pc;
    } FetchPkt;

    typedef struct packed {
        logic                  valid;      // register write
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  redirect;
        logic [XLEN-1:0]       redirectPc;
        logic                  illegal;
    } ExecResult;

endpackage

// File: source/rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // **************************************************
    // instruction formats, one view per encoding
    // **************************************************
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } RType;

    typedef struct packed {
        logic [11:0]           imm11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } IType;

    typedef struct packed {
        logic [6:0]            imm11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm4_0;
        logic [6:0]            opcode;
    } SType;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } BType;

    typedef struct packed {
        logic [19:0]           imm31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } UType;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } JType;

    typedef union packed {
        RType rType;
        IType iType;
        SType sType;
        BType bType;
        UType uType;
        JType jType;
    } Inst;

    // **************************************************
    // opcodes and function codes
    // **************************************************
    localparam logic [6:0] ALUR_OP  = 7'b0110011;
    localparam logic [6:0] ALUI_OP  = 7'b0010011;
    localparam logic [6:0] BR_OP    = 7'b1100011;
    localparam logic [6:0] JAL_OP   = 7'b1101111;
    localparam logic [6:0] JALR_OP  = 7'b1100111;
    localparam logic [6:0] LUI_OP   = 7'b0110111;
    localparam logic [6:0] AUIPC_OP = 7'b0010111;

    localparam logic [2:0] ADD_F3  = 3'b000;   // add, sub and addi
    localparam logic [2:0] SLL_F3  = 3'b001;
    localparam logic [2:0] SLT_F3  = 3'b010;
    localparam logic [2:0] SLTU_F3 = 3'b011;
    localparam logic [2:0] XOR_F3  = 3'b100;
    localparam logic [2:0] SR_F3   = 3'b101;   // srl and sra, split by funct7
    localparam logic [2:0] OR_F3   = 3'b110;
    localparam logic [2:0] AND_F3  = 3'b111;
    localparam logic [2:0] JALR_F3 = 3'b000;

    localparam logic [2:0] BEQ_F3  = 3'b000;
    localparam logic [2:0] BNE_F3  = 3'b001;
    localparam logic [2:0] BLT_F3  = 3'b100;
    localparam logic [2:0] BGE_F3  = 3'b101;
    localparam logic [2:0] BLTU_F3 = 3'b110;
    localparam logic [2:0] BGEU_F3 = 3'b111;

    localparam logic [6:0] BASE_F7 = 7'b0000000;
    localparam logic [6:0] ALT_F7  = 7'b0100000;

    // wildcard fields for the decode table
    localparam logic [6:0] X_7 = 7'b???????;
    localparam logic [2:0] X_3 = 3'b???;

endpackage
